/* Bender.yml */
package:
  name: eth_uart_bridge

sources:
  # Package first, then the blocks, then the top level
  - hdl/bridge_pkg.sv
  - hdl/reset_sync.sv
  - hdl/phy_reset_seq.sv
  - hdl/mii_rx_pack.sv
  - hdl/byte_fifo.sv
  - hdl/uart_tx.sv
  - hdl/eth_uart_bridge.sv

  - target: test
    files:
      - testbench/bridge_assert.sv
      - testbench/tb_eth_uart_bridge.sv

/* hdl/bridge_pkg.sv */
package bridge_pkg;

   // ------------------------------
   // MII and byte widths
   // ------------------------------
   localparam int NIBBLE_W = 4;
   localparam int BYTE_W   = 8;

   // ------------------------------
   // PHY reset timing
   // ------------------------------
   localparam int PHY_RST_CYCLES = 64;                          // clk cycles held low
   localparam int PHY_CNT_W      = $clog2(PHY_RST_CYCLES + 1);  // 7, must reach 64

   // ------------------------------
   // Byte FIFO
   // ------------------------------
   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

   // ------------------------------
   // UART bit timing
   // ------------------------------
   // Short bit time so simulation stays fast
   localparam int CLKS_PER_BIT = 8;
   localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);

endpackage

/* hdl/byte_fifo.sv */
`timescale 1ns/1ps

module byte_fifo (
   input  logic                        clk,
   input  logic                        arst,
   input  logic [bridge_pkg::BYTE_W-1:0] wr_data_i,
   input  logic                        wr_i,
   input  logic                        rd_i,
   output logic [bridge_pkg::BYTE_W-1:0] rd_data_o,
   output logic                        not_empty_o,
   output logic                        overflow_o
);

   import bridge_pkg::*;

   logic [BYTE_W-1:0]     mem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr_q;
   logic [FIFO_PTR_W-1:0] rd_ptr_q;
   logic [FIFO_PTR_W:0]   count_q;   // One extra bit to hold FIFO_DEPTH
   logic                  full;
   logic                  not_empty;
   logic                  wr_en;
   logic                  rd_en;
   logic                  overflow_q;

   assign full      = (count_q == (FIFO_PTR_W + 1)'(FIFO_DEPTH));
   assign not_empty = (count_q != '0);

   // A byte that meets a full FIFO is lost, even if a read happens too
   assign wr_en = wr_i & ~full;
   assign rd_en = rd_i & not_empty;

   // ------------------------------
   // Pointers and occupancy
   // ------------------------------
   always_ff @(posedge clk, posedge arst) begin
      if (arst) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         count_q    <= '0;
         overflow_q <= 1'b0;
      end else begin
         if (wr_en) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;   // Wraps at FIFO_DEPTH
         end
         if (rd_en) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
         if (wr_i && full) begin
            overflow_q <= 1'b1;            // Sticky until reset
         end
      end
   end

   // Storage
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr_q] <= wr_data_i;
      end
   end

   // Head of queue is always on the output
   assign rd_data_o   = mem[rd_ptr_q];
   assign not_empty_o = not_empty;
   assign overflow_o  = overflow_q;

endmodule

/* hdl/eth_uart_bridge.sv */
`timescale 1ns/1ps

module eth_uart_bridge (
   input  logic                          clk,
   input  logic                          arst,
   input  logic                          pll_locked_i,
   input  logic [bridge_pkg::NIBBLE_W-1:0] mii_rxd_i,
   input  logic                          mii_rx_dv_i,
   output logic                          txd_o,
   output logic                          phy_resetn_o,
   output logic                          overflow_o
);

   import bridge_pkg::*;

   logic              rst_sync;
   logic              phy_ready;
   logic [BYTE_W-1:0] byte_data;
   logic              byte_stb;
   logic [BYTE_W-1:0] rd_data;
   logic              not_empty;
   logic              pop;

   // ------------------------------
   // Reset generation
   // ------------------------------
   reset_sync u_reset_sync (
      .clk         (clk),
      .arst        (arst),
      .pll_locked_i(pll_locked_i),
      .rst_o       (rst_sync)
   );

   phy_reset_seq u_phy_reset_seq (
      .clk         (clk),
      .arst        (rst_sync),
      .phy_resetn_o(phy_resetn_o),
      .phy_ready_o (phy_ready)
   );

   // ------------------------------
   // MII receive to UART
   // ------------------------------
   mii_rx_pack u_mii_rx_pack (
      .clk        (clk),
      .arst       (rst_sync),
      .mii_rxd_i  (mii_rxd_i),
      .mii_rx_dv_i(mii_rx_dv_i),
      .phy_ready_i(phy_ready),
      .byte_o     (byte_data),
      .byte_stb_o (byte_stb)
   );

   byte_fifo u_byte_fifo (
      .clk        (clk),
      .arst       (rst_sync),
      .wr_data_i  (byte_data),
      .wr_i       (byte_stb),
      .rd_i       (pop),
      .rd_data_o  (rd_data),
      .not_empty_o(not_empty),
      .overflow_o (overflow_o)
   );

   uart_tx u_uart_tx (
      .clk    (clk),
      .arst   (rst_sync),
      .data_i (rd_data),
      .avail_i(not_empty),
      .pop_o  (pop),          // Back to the FIFO at frame start
      .txd_o  (txd_o)
   );

endmodule

/* hdl/mii_rx_pack.sv */
`timescale 1ns/1ps

module mii_rx_pack (
   input  logic                          clk,
   input  logic                          arst,
   input  logic [bridge_pkg::NIBBLE_W-1:0] mii_rxd_i,
   input  logic                          mii_rx_dv_i,
   input  logic                          phy_ready_i,
   output logic [bridge_pkg::BYTE_W-1:0]   byte_o,
   output logic                          byte_stb_o
);

   import bridge_pkg::*;

   logic                sample;
   logic                phase_q;   // 1 once the low nibble is held
   logic [NIBBLE_W-1:0] lo_q;
   logic [BYTE_W-1:0]   byte_q;
   logic                stb_q;

   // Nibbles only count while the PHY is out of reset
   assign sample = mii_rx_dv_i & phy_ready_i;

   // ------------------------------
   // Nibble pairing
   // ------------------------------
   // Phase clears whenever sampling stops, so every frame starts on a
   // low nibble and an odd trailing nibble is simply forgotten
   always_ff @(posedge clk, posedge arst) begin
      if (arst) begin
         phase_q <= 1'b0;
         stb_q   <= 1'b0;
      end else begin
         stb_q <= sample & phase_q;
         if (sample) begin
            phase_q <= ~phase_q;
         end else begin
            phase_q <= 1'b0;
         end
      end
   end

   // Data path
   always_ff @(posedge clk) begin
      if (sample && !phase_q) begin
         lo_q <= mii_rxd_i;               // Low nibble first
      end
      if (sample && phase_q) begin
         byte_q <= {mii_rxd_i, lo_q};
      end
   end

   assign byte_o     = byte_q;
   assign byte_stb_o = stb_q;  // One cycle after the high nibble

endmodule

/* hdl/phy_reset_seq.sv */
`timescale 1ns/1ps

module phy_reset_seq (
   input  logic clk,
   input  logic arst,
   output logic phy_resetn_o,
   output logic phy_ready_o
);

   import bridge_pkg::*;

   logic [PHY_CNT_W-1:0] cnt_q;
   logic                 ready_q;
   logic                 cnt_done;

   assign cnt_done = (cnt_q == PHY_CNT_W'(PHY_RST_CYCLES));

   // Counter stops once the hold time is over
   always_ff @(posedge clk, posedge arst) begin
      if (arst) begin
         cnt_q   <= '0;
         ready_q <= 1'b0;
      end else begin
         if (!cnt_done) begin
            cnt_q <= cnt_q + 1'b1;
         end
         // Set on the edge that brings the count to PHY_RST_CYCLES
         if (cnt_q == PHY_CNT_W'(PHY_RST_CYCLES - 1)) begin
            ready_q <= 1'b1;
         end
      end
   end

   // PHY comes out of reset together with the ready flag
   assign phy_resetn_o = ready_q;
   assign phy_ready_o  = ready_q;

endmodule

/* hdl/reset_sync.sv */
`timescale 1ns/1ps

module reset_sync (
   input  logic clk,
   input  logic arst,
   input  logic pll_locked_i,
   output logic rst_o
);

   logic       rst_in;
   logic [1:0] sync_q;

   // Board reset or lost lock both count as reset
   assign rst_in = arst | ~pll_locked_i;

   // Assert at once, release after two clean edges
   always_ff @(posedge clk, posedge rst_in) begin
      if (rst_in) begin
         sync_q <= 2'b11;
      end else begin
         sync_q <= {sync_q[0], 1'b0};
      end
   end

   assign rst_o = sync_q[1];  // Second stage drives the whole design

endmodule

/* hdl/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
   input  logic                        clk,
   input  logic                        arst,
   input  logic [bridge_pkg::BYTE_W-1:0] data_i,
   input  logic                        avail_i,
   output logic                        pop_o,
   output logic                        txd_o
);

   import bridge_pkg::*;

   logic                 busy_q;
   logic [BIT_CNT_W-1:0] bit_cnt_q;   // Cycles within the current bit
   logic [3:0]           bit_idx_q;   // 0 start, 1..8 data, 9 stop
   logic [BYTE_W-1:0]    shift_q;
   logic                 txd_q;
   logic                 tick;
   logic                 frame_end;
   logic                 pop;

   assign tick      = (bit_cnt_q == BIT_CNT_W'(CLKS_PER_BIT - 1));
   assign frame_end = busy_q & tick & (bit_idx_q == 4'd9);

   // Take the next byte when idle or as the stop bit ends
   assign pop = avail_i & (~busy_q | frame_end);

   // ------------------------------
   // Frame sequencer
   // ------------------------------
   always_ff @(posedge clk, posedge arst) begin
      if (arst) begin
         busy_q    <= 1'b0;
         bit_cnt_q <= '0;
         bit_idx_q <= '0;
         txd_q     <= 1'b1;            // Line idles high
      end else if (pop) begin
         busy_q    <= 1'b1;
         bit_cnt_q <= '0;
         bit_idx_q <= '0;
         txd_q     <= 1'b0;            // Start bit
      end else if (busy_q) begin
         if (tick) begin
            bit_cnt_q <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q <= 4'd7) begin
               txd_q <= shift_q[0];    // LSB first
            end else begin
               txd_q <= 1'b1;          // Stop bit, then idle
            end
            if (frame_end) begin
               busy_q <= 1'b0;
            end
         end else begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
         end
      end
   end

   // Shift register, loaded on pop
   always_ff @(posedge clk) begin
      if (pop) begin
         shift_q <= data_i;
      end else if (busy_q && tick && bit_idx_q <= 4'd7) begin
         shift_q <= shift_q >> 1;
      end
   end

   assign pop_o = pop;
   assign txd_o = txd_q;

endmodule

/* testbench/bridge_assert.sv */
`timescale 1ns/1ps

module bridge_assert (
   input logic clk,
   input logic arst,
   input logic pll_locked_i,
   input logic rst_sync_i,
   input logic txd_i,
   input logic phy_resetn_i,
   input logic overflow_i
);

   int fail_cnt = 0;   // Number of assertion failures

   // Line stays idle while the design is in reset
   txd_idle_in_reset: assert property (@(posedge clk) rst_sync_i |-> txd_i)
      else begin
         fail_cnt++;
         $error("txd_o low while the internal reset is active");
      end

   phy_held_in_reset: assert property (@(posedge clk) rst_sync_i |-> !phy_resetn_i)
      else begin
         fail_cnt++;
         $error("phy_resetn_o high while the internal reset is active");
      end

   // Sticky flag
   overflow_sticky: assert property (
      @(posedge clk) disable iff (rst_sync_i) !$fell(overflow_i))
      else begin
         fail_cnt++;
         $error("overflow_o cleared outside reset");
      end

   // Once out of reset the PHY stays out until the board reset or lock loss
   phy_stays_up: assert property (
      @(posedge clk) disable iff (arst || !pll_locked_i) !$fell(phy_resetn_i))
      else begin
         fail_cnt++;
         $error("phy_resetn_o fell without a reset");
      end

endmodule

bind eth_uart_bridge bridge_assert u_bridge_assert (
   .clk         (clk),
   .arst        (arst),
   .pll_locked_i(pll_locked_i),
   .rst_sync_i  (rst_sync),
   .txd_i       (txd_o),
   .phy_resetn_i(phy_resetn_o),
   .overflow_i  (overflow_o)
);

/* testbench/tb_eth_uart_bridge.sv */
`timescale 1ns/1ps

module tb_eth_uart_bridge;

   import bridge_pkg::*;

   logic                clk;
   logic                arst;
   logic                pll_locked;
   logic [NIBBLE_W-1:0] mii_rxd;
   logic                mii_rx_dv;
   wire                 txd;
   wire                 phy_resetn;
   wire                 overflow;

   int                  seed;
   string               test_name;
   int                  data_errs;
   int                  check_errs;
   int                  assert_errs;
   int                  timeouts;
   logic [NIBBLE_W-1:0] nib_q[$];    // Nibbles of the frame being sent
   logic [7:0]          exp_q[$];
   logic [7:0]          got_q[$];
   logic [7:0]          cmp_exp;
   logic [7:0]          cmp_act;
   bit                  rx_busy;
   int                  rx_cnt;      // Cycles since the start bit began
   int                  rx_bit;
   logic [7:0]          rx_shift;
   int                  frames_seen;
   int                  len;

   eth_uart_bridge uut (
      .clk         (clk),
      .arst        (arst),
      .pll_locked_i(pll_locked),
      .mii_rxd_i   (mii_rxd),
      .mii_rx_dv_i (mii_rx_dv),
      .txd_o       (txd),
      .phy_resetn_o(phy_resetn),
      .overflow_o  (overflow)
   );

   always #20 clk = ~clk;  // 40 ns period

   // Expected bytes of one frame with the low nibble first and the odd tail dropped.
   // The frame starts with an idle UART and an empty FIFO and is shorter
   // than one UART frame, so one byte goes straight to the UART and
   // FIFO_DEPTH more fit before the rest meet a full FIFO.
   function automatic void predict_bytes(input bit phy_ready);
      int i;
      int kept;
      kept = 0;
      if (!phy_ready) begin
         return;
      end
      for (i = 0; i + 1 < nib_q.size(); i += 2) begin
         if (kept < FIFO_DEPTH + 1) begin
            exp_q.push_back({nib_q[i+1], nib_q[i]});
            kept++;
         end
      end
   endfunction

   // ------------------------------
   // UART decoder sampling at mid-bit
   // ------------------------------
   always @(posedge clk) begin
      if (arst || !pll_locked) begin
         rx_busy = 1'b0;
      end else if (!rx_busy) begin
         if (txd === 1'b0) begin
            rx_busy = 1'b1;
            rx_cnt  = 0;
            frames_seen++;
         end
      end else begin
         rx_cnt++;
         if (rx_cnt % CLKS_PER_BIT == CLKS_PER_BIT / 2) begin
            rx_bit = rx_cnt / CLKS_PER_BIT;
            if (rx_bit == 0) begin
               assert (txd === 1'b0) else begin
                  check_errs++;
                  $display("start bit on txd_o did not stay low in %s", test_name);
               end
            end else if (rx_bit <= 8) begin
               rx_shift = {txd, rx_shift[7:1]};   // LSB arrives first
            end else begin
               assert (txd === 1'b1) else begin
                  check_errs++;
                  $display("stop bit on txd_o was low in %s", test_name);
               end
               got_q.push_back(rx_shift);
               rx_busy = 1'b0;
            end
         end
      end
   end

   // Compare decoded bytes with the reference queue
   always @(negedge clk) begin
      if (got_q.size() > 0) begin
         cmp_act = got_q.pop_front();
         assert (exp_q.size() > 0) else begin
            check_errs++;
            $display("unexpected byte %02h came out on txd_o in %s", cmp_act, test_name);
         end
         if (exp_q.size() > 0) begin
            cmp_exp = exp_q.pop_front();
            assert (cmp_act === cmp_exp) else begin
               data_errs++;
               $display("error %s: expected %02h, actual %02h", test_name, cmp_exp, cmp_act);
            end
         end
      end
   end

   task finish_run();
      assert_errs = uut.u_bridge_assert.fail_cnt;
      $display("errors: data %0d, checks %0d, assertions %0d, timeouts %0d",
               data_errs, check_errs, assert_errs, timeouts);
      if (data_errs + check_errs + assert_errs + timeouts == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   endtask

   task timeout_abort(input string what);
      timeouts++;
      $display("timed out in %s while waiting for %s", test_name, what);
      finish_run();
   endtask

   task check_level(input string what, input logic act, input logic expv);
      assert (act === expv) else begin
         check_errs++;
         $display("error %s: %s expected %0b, actual %0b", test_name, what, expv, act);
      end
   endtask

   // Release reset and count edges until the PHY leaves reset
   task release_and_count(input bit via_pll);
      int   n;
      logic phy_up;
      @(posedge clk);
      if (via_pll) begin
         pll_locked <= 1'b1;
      end else begin
         arst <= 1'b0;
      end
      n      = 0;
      phy_up = 1'b0;
      while (!phy_up && n < 4 * PHY_RST_CYCLES) begin
         @(posedge clk);
         n++;
         @(negedge clk);
         phy_up = phy_resetn;
      end
      if (!phy_up) begin
         timeout_abort("phy_resetn_o to rise");
      end else begin
         assert (n == PHY_RST_CYCLES + 2) else begin
            check_errs++;
            $display("error %s: phy_resetn_o rise cycle expected %0d, actual %0d",
                     test_name, PHY_RST_CYCLES + 2, n);
         end
      end
   endtask

   task make_frame(input int nibbles);
      int          i;
      logic [31:0] rnd;
      nib_q.delete();
      for (i = 0; i < nibbles; i++) begin
         rnd = $random(seed);
         nib_q.push_back(rnd[NIBBLE_W-1:0]);
      end
   endtask

   task send_frame();
      int i;
      for (i = 0; i < nib_q.size(); i++) begin
         @(posedge clk);
         mii_rxd   <= nib_q[i];
         mii_rx_dv <= 1'b1;
      end
      @(posedge clk);
      mii_rx_dv <= 1'b0;
      mii_rxd   <= '0;
   endtask

   // Wait until every expected byte has been decoded and compared
   task wait_drain(input int limit);
      int n;
      bit done;
      done = 1'b0;
      for (n = 0; n < limit && !done; n++) begin
         @(negedge clk);
         done = (exp_q.size() == 0) && (got_q.size() == 0) && !rx_busy;
      end
      if (!done) begin
         timeout_abort("the UART output to drain");
      end
   endtask

   task run_frame(input string name, input int nibbles);
      test_name = name;
      make_frame(nibbles);
      predict_bytes(1'b1);
      send_frame();
      wait_drain((nibbles / 2 + 2) * 10 * CLKS_PER_BIT + 100);
   endtask

   initial begin
      seed        = 75630;
      data_errs   = 0;
      check_errs  = 0;
      assert_errs = 0;
      timeouts    = 0;
      frames_seen = 0;
      rx_busy     = 1'b0;
      clk         = 1'b0;
      arst        = 1'b1;
      pll_locked  = 1'b1;
      mii_rxd     = '0;
      mii_rx_dv   = 1'b0;

      // Reset values and a frame while the PHY is still held in reset
      test_name = "reset";
      repeat (3) @(posedge clk);
      @(negedge clk);
      check_level("txd_o", txd, 1'b1);
      check_level("overflow_o", overflow, 1'b0);
      check_level("phy_resetn_o", phy_resetn, 1'b0);
      make_frame(8);
      predict_bytes(1'b0);
      fork
         release_and_count(1'b0);
         begin
            repeat (2) @(posedge clk);
            send_frame();
         end
      join
      test_name = "phy_reset_frame";
      repeat (20 * CLKS_PER_BIT) @(negedge clk);
      assert (frames_seen == 0) else begin
         check_errs++;
         $display("error %s: UART frames expected 0, actual %0d", test_name, frames_seen);
      end

      repeat (4) begin
         len = 2 * (1 + ({$random(seed)} % 8));
         run_frame("even_frame", len);
      end
      run_frame("odd_frame", 7);
      run_frame("odd_frame", 1);

      test_name = "overflow_burst";
      check_level("overflow_o before burst", overflow, 1'b0);
      run_frame("overflow_burst", 2 * (FIFO_DEPTH + 8));
      check_level("overflow_o after burst", overflow, 1'b1);

      // ------------------------------
      // PLL lock lost and regained
      // ------------------------------
      test_name = "pll_loss";
      @(posedge clk);
      pll_locked <= 1'b0;
      @(negedge clk);
      check_level("phy_resetn_o", phy_resetn, 1'b0);
      check_level("txd_o", txd, 1'b1);
      repeat (4) @(posedge clk);
      release_and_count(1'b1);
      check_level("overflow_o after relock", overflow, 1'b0);
      check_level("txd_o after relock", txd, 1'b1);
      run_frame("after_relock", 8);

      // Late stray bytes would show up here
      test_name = "final";
      repeat (20 * CLKS_PER_BIT) @(negedge clk);
      wait_drain(10);
      finish_run();
   end

endmodule

/* vlog.f */
hdl/bridge_pkg.sv
hdl/reset_sync.sv
hdl/phy_reset_seq.sv
hdl/mii_rx_pack.sv
hdl/byte_fifo.sv
hdl/uart_tx.sv
hdl/eth_uart_bridge.sv
testbench/bridge_assert.sv
testbench/tb_eth_uart_bridge.sv
